//--- run_sim.sh
#!/bin/sh
# Build and run the note lab testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_note_lab \
    -f sources.f

./obj_dir/Vtb_note_lab | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "Test completed successfully" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

//--- source/note_arpeggiator.sv
`timescale 1ns/1ps

module note_arpeggiator
(
    input  logic           clk,
    input  logic           rst,
    input  logic           enable,
    input  note_pkg::seg_t rec_abcdefgh,
    output note_pkg::note_t play_note
);

    import note_pkg::*;

    //------------------------------------------------------------------------
    // Segment decode

    note_t mic_note;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            mic_note <= '0;
        else
            mic_note <= seg_to_note(rec_abcdefgh);  // Blank gives C
    end

    //------------------------------------------------------------------------
    // Chord step sequencer

    step_t step;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            step <= STEP_ROOT;
        end
        else if (enable)
        begin
            case (step)
                STEP_ROOT  : step <= STEP_THIRD;
                STEP_THIRD : step <= STEP_FIFTH;
                default    : step <= STEP_ROOT;
            endcase
        end
    end

    //------------------------------------------------------------------------
    // Major third up, modulo 12

    note_t next_third;

    assign next_third = (play_note < note_t'(8)) ? play_note + note_t'(4)
                                                 : play_note - note_t'(8);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            play_note <= '0;
        end
        else if (enable)
        begin
            if (step == STEP_ROOT)
                play_note <= mic_note;  // Take the heard note
            else
                play_note <= next_third;
        end
    end

endmodule

//--- source/note_lab_top.sv
`timescale 1ns/1ps

module note_lab_top
(
    input  logic              clk,
    input  logic              rst,
    input  note_pkg::sample_t mic,
    output note_pkg::seg_t    abcdefgh,
    output logic [7:0]        digit,
    output note_pkg::sound_t  sound
);

    import note_pkg::*;

    //------------------------------------------------------------------------

    seg_t  rec_abcdefgh;
    logic  enable;
    note_t play_note;

    //------------------------------------------------------------------------

    note_recognizer note_recognizer_inst
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .mic          ( mic          ),
        .rec_abcdefgh ( rec_abcdefgh )
    );

    strobe_gen strobe_gen_inst
    (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .enable ( enable )
    );

    note_arpeggiator note_arpeggiator_inst
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .enable       ( enable       ),
        .rec_abcdefgh ( rec_abcdefgh ),
        .play_note    ( play_note    )
    );

    note_synthesizer note_synthesizer_inst
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .play_note ( play_note ),
        .abcdefgh  ( abcdefgh  ),
        .digit     ( digit     ),
        .sound     ( sound     )
    );

endmodule

//--- source/note_pkg.sv
package note_pkg;

    //------------------------------------------------------------------------
    // Widths and types

    typedef logic        [ 3:0] note_t;    // 0 = C .. 11 = B
    typedef logic        [ 7:0] seg_t;     // a b c d e f g h
    typedef logic signed [23:0] sample_t;  // Microphone sample
    typedef logic signed [15:0] sound_t;   // Sound output sample
    typedef logic        [11:0] period_t;  // Count in clock cycles

    typedef enum logic [1:0]
    {
        STEP_ROOT,
        STEP_THIRD,
        STEP_FIFTH
    } step_t;

    //------------------------------------------------------------------------
    // Note timing

    localparam int NOTE_COUNT       = 12;
    localparam int PERIOD_TOLERANCE = 4;   // Cycles around a full period
    localparam int MATCH_COUNT      = 2;   // Matching periods before update

    // Equal-tempered half-periods, C first
    localparam period_t NOTE_HALF_PERIOD [NOTE_COUNT] = '{
        12'd240, 12'd227, 12'd214, 12'd202, 12'd190, 12'd180,
        12'd170, 12'd160, 12'd151, 12'd143, 12'd135, 12'd127
    };

    typedef logic [$clog2(MATCH_COUNT + 1) - 1:0] run_t;

    localparam int     STROBE_PERIOD   = 4000;  // Short for simulation
    localparam int     STROBE_W        = $clog2(STROBE_PERIOD);
    localparam sound_t SOUND_AMPLITUDE = 16'sh2000;

    //------------------------------------------------------------------------
    // Segment encoding, h marks a sharp

    function automatic seg_t note_to_seg(input note_t note);
        case (note)
            4'd0    : return 8'b10011100;  // C
            4'd1    : return 8'b10011101;  // C#
            4'd2    : return 8'b01111010;  // D
            4'd3    : return 8'b01111011;  // D#
            4'd4    : return 8'b10011110;  // E
            4'd5    : return 8'b10001110;  // F
            4'd6    : return 8'b10001111;  // F#
            4'd7    : return 8'b10111100;  // G
            4'd8    : return 8'b10111101;  // G#
            4'd9    : return 8'b11101110;  // A
            4'd10   : return 8'b11101111;  // A#
            4'd11   : return 8'b00111110;  // B
            default : return 8'b00000000;  // Blank
        endcase
    endfunction

    function automatic note_t seg_to_note(input seg_t seg);
        case (seg)
            8'b10011100 : return 4'd0;
            8'b10011101 : return 4'd1;
            8'b01111010 : return 4'd2;
            8'b01111011 : return 4'd3;
            8'b10011110 : return 4'd4;
            8'b10001110 : return 4'd5;
            8'b10001111 : return 4'd6;
            8'b10111100 : return 4'd7;
            8'b10111101 : return 4'd8;
            8'b11101110 : return 4'd9;
            8'b11101111 : return 4'd10;
            8'b00111110 : return 4'd11;
            default     : return 4'd0;  // Unknown or blank reads as C
        endcase
    endfunction

endpackage

//--- source/note_recognizer.sv
`timescale 1ns/1ps

module note_recognizer
(
    input  logic              clk,
    input  logic              rst,
    input  note_pkg::sample_t mic,
    output note_pkg::seg_t    rec_abcdefgh
);

    import note_pkg::*;

    //------------------------------------------------------------------------
    // Rising zero crossing

    logic mic_neg;
    logic mic_neg_q;
    logic rise;

    assign mic_neg = mic[$bits(sample_t) - 1];
    assign rise    = mic_neg_q && !mic_neg;  // Negative to non-negative

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            mic_neg_q <= 1'b0;
        else
            mic_neg_q <= mic_neg;
    end

    //------------------------------------------------------------------------
    // Period measurement

    period_t period_cnt;
    logic    period_max;

    assign period_max = &period_cnt;

    // Holds the full period on the crossing cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            period_cnt <= '0;
        else if (rise)
            period_cnt <= period_t'(1);
        else if (!period_max)
            period_cnt <= period_cnt + 1'b1;  // Saturates
    end

    //------------------------------------------------------------------------
    // Window compare against every note

    logic [NOTE_COUNT - 1:0] hit;
    logic                    any_hit;
    note_t                   win_note;

    always_comb
    begin
        hit = '0;
        for (int k = 0; k < NOTE_COUNT; k++)
            if (int'(period_cnt) >= 2 * int'(NOTE_HALF_PERIOD[k]) - PERIOD_TOLERANCE &&
                int'(period_cnt) <= 2 * int'(NOTE_HALF_PERIOD[k]) + PERIOD_TOLERANCE)
                hit[k] = 1'b1;
    end

    // Windows do not overlap, lowest index wins anyway
    always_comb
    begin
        win_note = '0;
        for (int k = NOTE_COUNT - 1; k >= 0; k--)
            if (hit[k])
                win_note = note_t'(k);
    end

    assign any_hit = |hit;

    //------------------------------------------------------------------------
    // Match run and display

    run_t  run_cnt;
    run_t  run_next;
    note_t run_note;

    always_comb
    begin
        if (run_cnt != '0 && win_note == run_note)
            run_next = (run_cnt == run_t'(MATCH_COUNT)) ? run_cnt : run_cnt + 1'b1;
        else
            run_next = run_t'(1);  // New run starts
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            run_cnt      <= '0;
            rec_abcdefgh <= '0;
        end
        else if (period_max)
        begin
            run_cnt      <= '0;
            rec_abcdefgh <= '0;  // No tone, blank
        end
        else if (rise)
        begin
            if (any_hit)
            begin
                run_cnt <= run_next;
                if (run_next == run_t'(MATCH_COUNT))
                    rec_abcdefgh <= note_to_seg(win_note);
            end
            else
            begin
                run_cnt <= '0;  // Display held
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            run_note <= '0;
        else if (rise && any_hit)
            run_note <= win_note;
    end

endmodule

//--- source/note_synthesizer.sv
`timescale 1ns/1ps

module note_synthesizer
(
    input  logic             clk,
    input  logic             rst,
    input  note_pkg::note_t  play_note,
    output note_pkg::seg_t   abcdefgh,
    output logic [7:0]       digit,
    output note_pkg::sound_t sound
);

    import note_pkg::*;

    //------------------------------------------------------------------------
    // Display

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            abcdefgh <= note_to_seg('0);  // Shows C
            digit    <= '0;
        end
        else
        begin
            abcdefgh <= note_to_seg(play_note);
            digit    <= 8'b00000001;  // Rightmost digit only
        end
    end

    //------------------------------------------------------------------------
    // Square wave

    note_t   note_q;
    period_t half_cnt;
    logic    positive;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            note_q   <= '0;
            half_cnt <= NOTE_HALF_PERIOD[0] - 1'b1;
            positive <= 1'b1;
        end
        else if (play_note != note_q)
        begin
            // New note restarts the half-period
            note_q   <= play_note;
            half_cnt <= NOTE_HALF_PERIOD[play_note] - 1'b1;
        end
        else if (half_cnt == '0)
        begin
            half_cnt <= NOTE_HALF_PERIOD[note_q] - 1'b1;
            positive <= !positive;  // Flip polarity
        end
        else
        begin
            half_cnt <= half_cnt - 1'b1;
        end
    end

    assign sound = positive ? SOUND_AMPLITUDE : sound_t'(-SOUND_AMPLITUDE);

endmodule

//--- source/strobe_gen.sv
`timescale 1ns/1ps

module strobe_gen
(
    input  logic clk,
    input  logic rst,
    output logic enable
);

    import note_pkg::*;

    logic [STROBE_W - 1:0] cnt;

    // Down-counter, one pulse per wrap
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt    <= STROBE_W'(STROBE_PERIOD - 1);
            enable <= 1'b0;
        end
        else
        begin
            enable <= (cnt == '0);
            if (cnt == '0)
                cnt <= STROBE_W'(STROBE_PERIOD - 1);  // Reload
            else
                cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- sources.f
source/note_pkg.sv
source/strobe_gen.sv
source/note_recognizer.sv
source/note_arpeggiator.sv
source/note_synthesizer.sv
source/note_lab_top.sv
verif/note_lab_chk.sv
verif/note_lab_monitor.sv
verif/tb_note_lab.sv

//--- verif/note_lab_chk.sv
`timescale 1ns/1ps

module note_lab_chk
(
    input  logic            clk,
    input  logic            rst,
    input  logic            enable,
    input  note_pkg::note_t play_note,
    input  note_pkg::step_t step,
    input  logic [7:0]      digit
);

    import note_pkg::*;

    //------------------------------------------------------------------------
    // Strobe and sequencer

    enable_single : assert property (@(posedge clk) disable iff (rst)
        enable |=> !enable)
        else $error("enable high on two consecutive cycles");

    note_range : assert property (@(posedge clk) disable iff (rst)
        play_note < note_t'(NOTE_COUNT))
        else $error("play_note out of the octave");

    step_legal : assert property (@(posedge clk) disable iff (rst)
        step inside {STEP_ROOT, STEP_THIRD, STEP_FIFTH})
        else $error("step register holds an illegal value");

    // First cycle after reset still shows the reset value
    digit_onehot : assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> $onehot(digit))
        else $error("digit is not one-hot");

endmodule

bind note_lab_top note_lab_chk lab_chk
(
    .clk       ( clk                        ),
    .rst       ( rst                        ),
    .enable    ( enable                     ),
    .play_note ( play_note                  ),
    .step      ( note_arpeggiator_inst.step ),
    .digit     ( digit                      )
);

//--- verif/note_lab_monitor.sv
`timescale 1ns/1ps

module note_lab_monitor
(
    input  logic             clk,
    input  logic             rst,
    input  logic             enable,
    input  note_pkg::step_t  step,
    input  note_pkg::seg_t   abcdefgh,
    input  logic [7:0]       digit,
    input  note_pkg::sound_t sound,
    input  logic             check_req,
    input  int               test_id,
    input  note_pkg::note_t  e0,
    input  note_pkg::note_t  e1,
    input  note_pkg::note_t  e2,
    output logic             check_done,
    output int               test_pass,
    output int               test_fail,
    output int               error_count
);

    import note_pkg::*;

    localparam int   WAIT_LIMIT = 20 * STROBE_PERIOD;
    localparam seg_t SEG_C      = 8'b10011100;  // Letter C, no sharp

    function automatic note_t third_up(input note_t n);
        return note_t'((int'(n) + 4) % 12);  // Major third in the octave
    endfunction

    //------------------------------------------------------------------------
    // Reset state

    task automatic check_reset();
        int n;
        bit released;
        released = 1'b0;
        for (n = 0; n < 100 && !released; n++)
        begin
            @(posedge clk);
            released = (rst === 1'b0);
            if (!released)
            begin
                @(negedge clk);
                if (abcdefgh !== SEG_C || sound !== SOUND_AMPLITUDE || digit !== 8'd0)
                begin
                    $display("ERR %0t: reset state wrong, seg %b sound %h digit %b",
                             $time, abcdefgh, sound, digit);
                    error_count++;
                end
            end
        end
        if (!released)
        begin
            $display("Reset was not released in time");
            error_count++;
        end
        else
        begin
            @(negedge clk);
            if (digit !== 8'b00000001 || abcdefgh !== SEG_C || sound !== SOUND_AMPLITUDE)
            begin
                $display("ERR %0t: after reset digit %b seg %b sound %h",
                         $time, digit, abcdefgh, sound);
                error_count++;
            end
        end
    endtask

    //------------------------------------------------------------------------
    // Waits, each bounded

    task automatic wait_root_enable(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < 4 * STROBE_PERIOD && !ok; n++)
        begin
            @(negedge clk);
            ok = enable && step == STEP_ROOT;
        end
    endtask

    // Toggle intervals until the next strobe, first one skipped
    task automatic measure_sound(input note_t note, input int s, output bit ok);
        sound_t prev;
        int     cnt;
        int     checked;
        bit     first;
        int     n;
        prev    = sound;
        cnt     = 0;
        checked = 0;
        first   = 1'b1;
        ok      = 1'b0;
        for (n = 0; n < 2 * STROBE_PERIOD && !ok; n++)
        begin
            @(negedge clk);
            ok = enable;
            cnt++;
            if (!ok && sound !== prev)
            begin
                if (sound !== sound_t'(-prev))
                begin
                    $display("ERR %0t: test %0d step %0d sound %h, expected %h",
                             $time, test_id, s, sound, sound_t'(-prev));
                    error_count++;
                end
                if (!first)
                begin
                    checked++;
                    if (cnt != int'(NOTE_HALF_PERIOD[note]))
                    begin
                        $display("ERR %0t: test %0d step %0d half-period %0d, expected %0d",
                                 $time, test_id, s, cnt, NOTE_HALF_PERIOD[note]);
                        error_count++;
                    end
                end
                first = 1'b0;
                cnt   = 0;
                prev  = sound;
            end
        end
        if (ok && checked == 0)
        begin
            $display("ERR %0t: test %0d step %0d sound did not toggle",
                     $time, test_id, s);
            error_count++;
        end
    endtask

    //------------------------------------------------------------------------
    // One test

    task automatic run_test();
        note_t exp_note [3];
        int    errs_before;
        bit    ok;
        errs_before = error_count;
        exp_note[0] = e0;
        exp_note[1] = e1;
        exp_note[2] = e2;
        for (int s = 1; s < 3; s++)
            if (exp_note[s] != third_up(exp_note[s - 1]))
            begin
                $display("ERR %0t: test %0d expected notes break the third rule",
                         $time, test_id);
                error_count++;
            end
        wait_root_enable(ok);
        for (int s = 0; s < 3 && ok; s++)
        begin
            repeat (2) @(negedge clk);  // Note register, then display
            if (abcdefgh !== note_to_seg(exp_note[s]))
            begin
                $display("ERR %0t: test %0d step %0d display %b, expected %b",
                         $time, test_id, s, abcdefgh, note_to_seg(exp_note[s]));
                error_count++;
            end
            measure_sound(exp_note[s], s, ok);
        end
        if (!ok)
        begin
            $display("Test %0d timed out waiting for an arpeggio strobe", test_id);
            error_count++;
        end
        if (error_count == errs_before)
        begin
            $display("test %0d: pass", test_id);
            test_pass++;
        end
        else
        begin
            $display("test %0d: FAIL, %0d errors", test_id, error_count - errs_before);
            test_fail++;
        end
    endtask

    //------------------------------------------------------------------------
    // Request loop

    initial
    begin
        bit got;
        check_done  = 1'b0;
        test_pass   = 0;
        test_fail   = 0;
        error_count = 0;
        check_reset();
        forever
        begin
            got = 1'b0;
            for (int n = 0; n < WAIT_LIMIT && !got; n++)
            begin
                @(posedge clk);
                got = check_req;
            end
            if (!got)
            begin
                $display("Monitor saw no test request in time");
                error_count++;
            end
            else
            begin
                run_test();
                @(posedge clk);
                check_done <= 1'b1;
                got = 1'b1;
                for (int n = 0; n < WAIT_LIMIT && got; n++)
                begin
                    @(posedge clk);
                    got = check_req;
                end
                if (got)
                begin
                    $display("Test request was not withdrawn in time");
                    error_count++;
                end
                check_done <= 1'b0;
            end
        end
    end

endmodule

//--- verif/tb_input.txt
# tone_note hold_strobes e0 e1 e2
# tone_note 15 is silence, expected notes are the three arpeggio notes
0 2 0 4 8
4 2 4 8 0
7 2 7 11 3
8 2 8 0 4
9 2 9 1 5
10 2 10 2 6
11 2 11 3 7
15 2 0 4 8
2 2 2 6 10
5 2 5 9 1

//--- verif/tb_note_lab.sv
`timescale 1ns/1ps

module tb_note_lab;

    import note_pkg::*;

    localparam sample_t TONE_LEVEL  = 24'sh100000;
    localparam int      NOISE_BOUND = 1000;     // Far below the tone level
    localparam int      SILENCE     = 15;

    logic    clk;
    logic    rst;
    sample_t mic;
    seg_t    abcdefgh;
    logic [7:0] digit;
    sound_t  sound;

    logic    tone_on;
    note_t   tone_note;
    int      tone_cnt;
    logic    tone_high;
    integer  seed;
    integer  noise;

    logic    check_req;
    logic    check_done;
    int      test_id;
    note_t   e0;
    note_t   e1;
    note_t   e2;
    int      test_pass;
    int      test_fail;
    int      error_count;

    //------------------------------------------------------------------------
    // Clock, DUT and monitor

    always #50 clk = ~clk;

    note_lab_top note_lab_top_inst
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .mic      ( mic      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .sound    ( sound    )
    );

    note_lab_monitor monitor_inst
    (
        .clk         ( clk                                         ),
        .rst         ( rst                                         ),
        .enable      ( note_lab_top_inst.enable                    ),
        .step        ( note_lab_top_inst.note_arpeggiator_inst.step ),
        .abcdefgh    ( abcdefgh                                    ),
        .digit       ( digit                                       ),
        .sound       ( sound                                       ),
        .check_req   ( check_req                                   ),
        .test_id     ( test_id                                     ),
        .e0          ( e0                                          ),
        .e1          ( e1                                          ),
        .e2          ( e2                                          ),
        .check_done  ( check_done                                  ),
        .test_pass   ( test_pass                                   ),
        .test_fail   ( test_fail                                   ),
        .error_count ( error_count                                 )
    );

    //------------------------------------------------------------------------
    // Mic tone with a little noise

    always @(negedge clk)
    begin
        noise = $random(seed) % (NOISE_BOUND + 1);
        if (!tone_on)
        begin
            mic      = '0;
            tone_cnt = 0;
        end
        else
        begin
            if (tone_cnt >= int'(NOTE_HALF_PERIOD[tone_note]) - 1)
            begin
                tone_cnt  = 0;
                tone_high = !tone_high;
            end
            else
            begin
                tone_cnt++;
            end
            mic = (tone_high ? TONE_LEVEL : -TONE_LEVEL) + sample_t'(noise);
        end
    end

    //------------------------------------------------------------------------
    // Test file reader

    initial
    begin
        integer fd;
        string  line;
        int     fields;
        int     n;
        int     hold;
        int     x0;
        int     x1;
        int     x2;
        int     test_count;
        bit     got;
        bit     aborted;
        clk        = 1'b0;
        rst        = 1'b1;
        mic        = '0;
        tone_on    = 1'b0;
        tone_note  = '0;
        tone_cnt   = 0;
        tone_high  = 1'b1;
        seed       = 32'h1c6f;
        check_req  = 1'b0;
        test_id    = 0;
        e0         = '0;
        e1         = '0;
        e2         = '0;
        test_count = 0;
        aborted    = 1'b0;
        fd = $fopen("verif/tb_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file verif/tb_input.txt");
            aborted = 1'b1;
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        while (!aborted && !$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%d %d %d %d %d", n, hold, x0, x1, x2);
            if (line.len() == 0 || line.getc(0) == "#" || fields != 5)
                continue;
            test_count++;
            @(negedge clk);
            tone_on   <= (n != SILENCE);
            tone_note <= note_t'(n);
            repeat (hold * STROBE_PERIOD) @(negedge clk);
            test_id   = test_count;
            e0        = note_t'(x0);
            e1        = note_t'(x1);
            e2        = note_t'(x2);
            check_req = 1'b1;
            got = 1'b0;
            for (int w = 0; w < 8 * STROBE_PERIOD && !got; w++)
            begin
                @(posedge clk);
                got = check_done;
            end
            if (!got)
            begin
                $display("Monitor did not finish test %0d in time", test_count);
                aborted = 1'b1;
            end
            else
            begin
                @(negedge clk);
                check_req = 1'b0;
            end
        end
        if (fd != 0)
            $fclose(fd);
        repeat (4) @(negedge clk);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 test_count, test_pass, test_fail, error_count);
        if (!aborted && test_count > 0 && test_pass == test_count && error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
